//--- source/cache_pkg.sv
// cache package: geometry constants, vector types and controller states
package cache_pkg;

  // ------------------------------------------------------------
  // geometry, fixed by the 64x128 sram macro
  // ------------------------------------------------------------
  localparam int NUM_WAYS       = 4;   // associativity
  localparam int NUM_SETS       = 64;  // sets per way
  localparam int LINE_BYTES     = 16;  // bytes per line
  localparam int WORDS_PER_LINE = 4;   // 32-bit words per line

  localparam logic [7:0] LFSR_SEED = 8'hb5; // must be nonzero

  // ------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------
  typedef logic [21:0]  tag_t;    // addr[31:10]
  typedef logic [5:0]   index_t;  // addr[9:4]
  typedef logic [3:0]   offset_t; // addr[3:0]
  typedef logic [31:0]  word_t;
  typedef logic [3:0]   strb_t;
  typedef logic [127:0] line_t;
  typedef logic [3:0]   way_oh_t; // one bit per way
  typedef logic [31:0]  addr_t;

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0, // waiting for a request
    ST_LOOKUP  = 3'd1, // tag compare, sram read
    ST_HIT     = 3'd2, // return word or merge store
    ST_WB      = 3'd3, // dirty victim to memory
    ST_RD_REQ  = 3'd4, // line read request
    ST_REFILL  = 3'd5, // collect return beats
    ST_REPLAY  = 3'd6  // install line and tag
  } ctrl_state_t;

endpackage

//--- source/data_sram.sv
// single-port 64x128 data sram model with active-low controls and bit write mask
module data_sram (
  input  logic              i_clk,
  input  logic              i_cen,   // chip enable, active low
  input  logic              i_wen,   // write enable, active low
  input  cache_pkg::line_t  i_bwen,  // bit write mask, active low
  input  cache_pkg::index_t i_addr,
  input  cache_pkg::line_t  i_d,
  output cache_pkg::line_t  o_q
);

  import cache_pkg::*;

  line_t mem [NUM_SETS];

  // ------------------------------------------------------------
  // one access per enabled cycle, write or read
  // ------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_cen) begin
      if (!i_wen) begin
        // masked bits keep their old value
        mem[i_addr] <= (mem[i_addr] & i_bwen) | (i_d & ~i_bwen);
      end else begin
        o_q <= mem[i_addr]; // q holds until next read
      end
    end
  end

  // an enabled access needs a known address
  addr_known_a : assert property (
    @(posedge i_clk) !i_cen |-> !$isunknown(i_addr)
  ) else $error("data_sram: unknown address on enabled access");

endmodule

//--- source/tag_array.sv
// tag, valid and dirty storage for four ways with per-way hit compare
module tag_array (
  input  logic                                       i_clk,
  input  logic                                       i_rst,
  input  cache_pkg::index_t                          i_index,
  input  cache_pkg::tag_t                            i_tag,      // lookup tag
  input  logic                                       i_we,
  input  cache_pkg::way_oh_t                         i_we_way,
  input  cache_pkg::tag_t                            i_we_tag,
  input  logic                                       i_we_dirty,
  output cache_pkg::way_oh_t                         o_hit_way,
  output cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0]  o_tag,
  output cache_pkg::way_oh_t                         o_valid,
  output cache_pkg::way_oh_t                         o_dirty
);

  import cache_pkg::*;

  tag_t    tag_q   [NUM_SETS][NUM_WAYS];
  way_oh_t valid_q [NUM_SETS];
  way_oh_t dirty_q [NUM_SETS];

  // valid and dirty bits, cleared on reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else if (i_we) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (i_we_way[w]) begin
          valid_q[i_index][w] <= 1'b1;       // every write installs
          dirty_q[i_index][w] <= i_we_dirty;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (i_we_way[w]) tag_q[i_index][w] <= i_we_tag;
      end
    end
  end

  // ------------------------------------------------------------
  // read side and compare
  // ------------------------------------------------------------
  always_comb begin
    o_valid = valid_q[i_index];
    o_dirty = dirty_q[i_index];
    for (int w = 0; w < NUM_WAYS; w++) begin
      o_tag[w]     = tag_q[i_index][w];
      o_hit_way[w] = valid_q[i_index][w] && (tag_q[i_index][w] == i_tag);
    end
  end

  // a tag may live in only one way of a set
  hit_onehot_a : assert property (
    @(posedge i_clk) disable iff (i_rst)
      !$isunknown(i_index) |-> $onehot0(o_hit_way)
  ) else $error("tag_array: same tag resident in two ways");

endmodule

//--- source/cache_ctrl.sv
// cache controller FSM: lookup, hit merge, victim choice, write-back, refill, replay
module cache_ctrl (
  input  logic                                       i_clk,
  input  logic                                       i_rst,
  // cpu side
  input  logic                                       i_valid,
  input  logic                                       i_op,       // 1: write
  input  cache_pkg::index_t                          i_index,
  input  cache_pkg::tag_t                            i_tag,
  input  cache_pkg::offset_t                         i_offset,
  input  cache_pkg::strb_t                           i_wstrb,
  input  cache_pkg::word_t                           i_wdata,
  output logic                                       o_addr_ok,
  output logic                                       o_data_ok,
  output cache_pkg::word_t                           o_rdata,
  // bus side
  output logic                                       o_rd_req,
  output cache_pkg::addr_t                           o_rd_addr,
  input  logic                                       i_rd_rdy,
  input  logic                                       i_ret_valid,
  input  logic                                       i_ret_last,
  input  cache_pkg::word_t                           i_ret_data,
  output logic                                       o_wr_req,
  output cache_pkg::addr_t                           o_wr_addr,
  output cache_pkg::line_t                           o_wr_data,
  input  logic                                       i_wr_rdy,
  // data srams
  output cache_pkg::way_oh_t                         o_sram_cen,  // active low
  output logic                                       o_sram_wen,  // active low
  output cache_pkg::line_t                           o_sram_bwen, // active low
  output cache_pkg::index_t                          o_sram_addr,
  output cache_pkg::line_t                           o_sram_d,
  input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] i_sram_q,
  // tag array
  output cache_pkg::index_t                          o_tag_index,
  output cache_pkg::tag_t                            o_tag_tag,
  output logic                                       o_tag_we,
  output cache_pkg::way_oh_t                         o_tag_we_way,
  output cache_pkg::tag_t                            o_tag_we_tag,
  output logic                                       o_tag_we_dirty,
  input  cache_pkg::way_oh_t                         i_hit_way,
  input  cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0]  i_way_tag,
  input  cache_pkg::way_oh_t                         i_way_valid,
  input  cache_pkg::way_oh_t                         i_way_dirty
);

  import cache_pkg::*;

  localparam int OFS_W  = $clog2(LINE_BYTES);
  localparam int BEAT_W = $clog2(WORDS_PER_LINE);

  ctrl_state_t state, state_nxt;

  // request registers
  logic    r_op;
  index_t  r_index;
  tag_t    r_tag;
  offset_t r_offset;
  strb_t   r_wstrb;
  word_t   r_wdata;

  way_oh_t           r_way;   // hit way or victim
  line_t             r_line;  // refill buffer
  logic [BEAT_W-1:0] r_beat;
  logic [7:0]        lfsr;
  logic              r_done;

  way_oh_t victim;
  logic    victim_dirty;
  line_t   way_line;          // line of r_way from sram q
  tag_t    way_tag;
  line_t   st_mask;           // bits touched by the store
  line_t   merged;

  // ------------------------------------------------------------
  // byte strobes to a line-wide bit mask
  // ------------------------------------------------------------
  function automatic line_t store_mask(input offset_t off, input strb_t strb);
    line_t mask;
    mask = '0;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) mask[off[3:2]*32 + b*8 +: 8] = 8'hff;
    end
    return mask;
  endfunction

  assign st_mask = store_mask(r_offset, r_wstrb);
  assign merged  = r_op ? ((r_line & ~st_mask) | ({WORDS_PER_LINE{r_wdata}} & st_mask))
                        : r_line;

  // select line and tag of r_way
  always_comb begin
    way_line = '0;
    way_tag  = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (r_way[w]) begin
        way_line = way_line | i_sram_q[w];
        way_tag  = way_tag | i_way_tag[w];
      end
    end
  end

  // invalid way first, otherwise random
  always_comb begin
    victim = '0;
    victim[lfsr[1:0]] = 1'b1;
    for (int w = NUM_WAYS-1; w >= 0; w--) begin
      if (!i_way_valid[w]) begin
        victim    = '0;
        victim[w] = 1'b1;
      end
    end
    victim_dirty = |(victim & i_way_valid & i_way_dirty);
  end

  // ------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    unique case (state)
      ST_IDLE:   if (i_valid) state_nxt = ST_LOOKUP;
      ST_LOOKUP: begin
        if (|i_hit_way)        state_nxt = ST_HIT;
        else if (victim_dirty) state_nxt = ST_WB;
        else                   state_nxt = ST_RD_REQ;
      end
      ST_HIT:    state_nxt = ST_IDLE;
      ST_WB:     if (i_wr_rdy) state_nxt = ST_RD_REQ;
      ST_RD_REQ: if (i_rd_rdy) state_nxt = ST_REFILL;
      ST_REFILL: if (i_ret_valid && i_ret_last) state_nxt = ST_REPLAY;
      ST_REPLAY: state_nxt = ST_IDLE;
      default:   state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= ST_IDLE;
      lfsr   <= LFSR_SEED;
      r_done <= 1'b0;
      r_beat <= '0;
    end else begin
      state  <= state_nxt;
      lfsr   <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]}; // free running
      r_done <= (state == ST_REPLAY);
      if (state == ST_RD_REQ) r_beat <= '0;
      else if (state == ST_REFILL && i_ret_valid) r_beat <= r_beat + 1'b1;
    end
  end

  // payload, no reset
  always_ff @(posedge i_clk) begin
    if (o_addr_ok) begin
      r_op     <= i_op;
      r_index  <= i_index;
      r_tag    <= i_tag;
      r_offset <= i_offset;
      r_wstrb  <= i_wstrb;
      r_wdata  <= i_wdata;
    end
    if (state == ST_LOOKUP) r_way <= (|i_hit_way) ? i_hit_way : victim;
    if (state == ST_REFILL && i_ret_valid) r_line[r_beat*32 +: 32] <= i_ret_data;
    if (state == ST_REPLAY) r_line <= merged; // miss read data source
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign o_addr_ok = (state == ST_IDLE) && i_valid;
  assign o_data_ok = (state == ST_HIT) || r_done;
  assign o_rdata   = (state == ST_HIT) ? way_line[r_offset[3:2]*32 +: 32]
                                       : r_line[r_offset[3:2]*32 +: 32];

  assign o_rd_req  = (state == ST_RD_REQ);
  assign o_rd_addr = {r_tag, r_index, {OFS_W{1'b0}}};
  assign o_wr_req  = (state == ST_WB);
  assign o_wr_addr = {way_tag, r_index, {OFS_W{1'b0}}};
  assign o_wr_data = way_line;                // victim line read in lookup

  always_comb begin
    o_sram_cen  = '1;
    o_sram_wen  = 1'b1;
    o_sram_bwen = '1;
    o_sram_d    = merged;
    if (state == ST_LOOKUP) begin
      o_sram_cen = '0;                        // read all ways
    end else if (state == ST_HIT && r_op) begin
      o_sram_cen  = ~r_way;
      o_sram_wen  = 1'b0;
      o_sram_bwen = ~st_mask;
      o_sram_d    = {WORDS_PER_LINE{r_wdata}};
    end else if (state == ST_REPLAY) begin
      o_sram_cen  = ~r_way;
      o_sram_wen  = 1'b0;
      o_sram_bwen = '0;                       // whole line
    end
  end
  assign o_sram_addr = r_index;

  assign o_tag_index    = r_index;
  assign o_tag_tag      = r_tag;
  assign o_tag_we       = (state == ST_HIT && r_op) || (state == ST_REPLAY);
  assign o_tag_we_way   = r_way;
  assign o_tag_we_tag   = r_tag;
  assign o_tag_we_dirty = r_op;

  // ------------------------------------------------------------
  // protocol checks
  // ------------------------------------------------------------
  rd_wr_excl_a : assert property (
    @(posedge i_clk) disable iff (i_rst) !(o_rd_req && o_wr_req)
  ) else $error("cache_ctrl: read and write request together");

  ret_in_refill_a : assert property (
    @(posedge i_clk) disable iff (i_rst) i_ret_valid |-> (state == ST_REFILL)
  ) else $error("cache_ctrl: return beat outside refill");

  // no new request until the current one completes
  addr_ok_idle_a : assert property (
    @(posedge i_clk) disable iff (i_rst)
      o_addr_ok |=> !o_addr_ok until o_data_ok
  ) else $error("cache_ctrl: request accepted while one is in flight");

endmodule

//--- source/cache.sv
// data cache top: controller, tag array and four way srams
module cache (
  input  logic                i_clk,
  input  logic                i_rst,
  // cpu side
  input  logic                i_valid,
  input  logic                i_op,
  input  cache_pkg::index_t   i_index,
  input  cache_pkg::tag_t     i_tag,
  input  cache_pkg::offset_t  i_offset,
  input  cache_pkg::strb_t    i_wstrb,
  input  cache_pkg::word_t    i_wdata,
  output logic                o_addr_ok,
  output logic                o_data_ok,
  output cache_pkg::word_t    o_rdata,
  // bus side
  output logic                o_rd_req,
  output cache_pkg::addr_t    o_rd_addr,
  input  logic                i_rd_rdy,
  input  logic                i_ret_valid,
  input  logic                i_ret_last,
  input  cache_pkg::word_t    i_ret_data,
  output logic                o_wr_req,
  output cache_pkg::addr_t    o_wr_addr,
  output cache_pkg::line_t    o_wr_data,
  input  logic                i_wr_rdy
);

  import cache_pkg::*;

  way_oh_t                  sram_cen;
  logic                     sram_wen;
  line_t                    sram_bwen;
  index_t                   sram_addr;
  line_t                    sram_d;
  line_t [NUM_WAYS-1:0]     sram_q;

  index_t                   tag_index;
  tag_t                     tag_tag;
  logic                     tag_we;
  way_oh_t                  tag_we_way;
  tag_t                     tag_we_tag;
  logic                     tag_we_dirty;
  way_oh_t                  hit_way;
  tag_t [NUM_WAYS-1:0]      way_tag;
  way_oh_t                  way_valid;
  way_oh_t                  way_dirty;

  cache_ctrl u_ctrl (
    .i_clk          (i_clk),         .i_rst          (i_rst),
    .i_valid        (i_valid),       .i_op           (i_op),
    .i_index        (i_index),       .i_tag          (i_tag),
    .i_offset       (i_offset),      .i_wstrb        (i_wstrb),
    .i_wdata        (i_wdata),       .o_addr_ok      (o_addr_ok),
    .o_data_ok      (o_data_ok),     .o_rdata        (o_rdata),
    .o_rd_req       (o_rd_req),      .o_rd_addr      (o_rd_addr),
    .i_rd_rdy       (i_rd_rdy),      .i_ret_valid    (i_ret_valid),
    .i_ret_last     (i_ret_last),    .i_ret_data     (i_ret_data),
    .o_wr_req       (o_wr_req),      .o_wr_addr      (o_wr_addr),
    .o_wr_data      (o_wr_data),     .i_wr_rdy       (i_wr_rdy),
    .o_sram_cen     (sram_cen),      .o_sram_wen     (sram_wen),
    .o_sram_bwen    (sram_bwen),     .o_sram_addr    (sram_addr),
    .o_sram_d       (sram_d),        .i_sram_q       (sram_q),
    .o_tag_index    (tag_index),     .o_tag_tag      (tag_tag),
    .o_tag_we       (tag_we),        .o_tag_we_way   (tag_we_way),
    .o_tag_we_tag   (tag_we_tag),    .o_tag_we_dirty (tag_we_dirty),
    .i_hit_way      (hit_way),       .i_way_tag      (way_tag),
    .i_way_valid    (way_valid),     .i_way_dirty    (way_dirty)
  );

  tag_array u_tags (
    .i_clk      (i_clk),      .i_rst      (i_rst),
    .i_index    (tag_index),  .i_tag      (tag_tag),
    .i_we       (tag_we),     .i_we_way   (tag_we_way),
    .i_we_tag   (tag_we_tag), .i_we_dirty (tag_we_dirty),
    .o_hit_way  (hit_way),    .o_tag      (way_tag),
    .o_valid    (way_valid),  .o_dirty    (way_dirty)
  );

  // ------------------------------------------------------------
  // data array, one macro per way
  // ------------------------------------------------------------
  data_sram u_way0 (
    .i_clk (i_clk), .i_cen (sram_cen[0]), .i_wen (sram_wen), .i_bwen (sram_bwen),
    .i_addr (sram_addr), .i_d (sram_d), .o_q (sram_q[0])
  );

  data_sram u_way1 (
    .i_clk (i_clk), .i_cen (sram_cen[1]), .i_wen (sram_wen), .i_bwen (sram_bwen),
    .i_addr (sram_addr), .i_d (sram_d), .o_q (sram_q[1])
  );

  data_sram u_way2 (
    .i_clk (i_clk), .i_cen (sram_cen[2]), .i_wen (sram_wen), .i_bwen (sram_bwen),
    .i_addr (sram_addr), .i_d (sram_d), .o_q (sram_q[2])
  );

  data_sram u_way3 (
    .i_clk (i_clk), .i_cen (sram_cen[3]), .i_wen (sram_wen), .i_bwen (sram_bwen),
    .i_addr (sram_addr), .i_d (sram_d), .o_q (sram_q[3])
  );

endmodule

//--- verification/mem_model.sv
// bus memory model with random ready delays, four-beat line refill and write-back capture
module mem_model #(
  parameter cache_pkg::word_t INIT_XOR = 32'h0
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_rd_req,
  input  cache_pkg::addr_t  i_rd_addr,
  output logic              o_rd_rdy,
  output logic              o_ret_valid,
  output logic              o_ret_last,
  output cache_pkg::word_t  o_ret_data,
  input  logic              i_wr_req,
  input  cache_pkg::addr_t  i_wr_addr,
  input  cache_pkg::line_t  i_wr_data,
  output logic              o_wr_rdy,
  output logic              o_wb_valid,  // one pulse per write-back
  output cache_pkg::addr_t  o_wb_addr,
  output cache_pkg::line_t  o_wb_data
);

  import cache_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_RD_WAIT, M_RET, M_WR_WAIT} mem_state_t;

  mem_state_t mstate     = M_IDLE;
  logic       rd_rdy_q   = 1'b0;
  logic       ret_vld_q  = 1'b0;
  logic       ret_last_q = 1'b0;
  word_t      ret_data_q = '0;
  logic       wr_rdy_q   = 1'b0;
  logic       wb_vld_q   = 1'b0;
  addr_t      wb_addr_q  = '0;
  line_t      wb_data_q  = '0;
  addr_t      rd_base    = '0;
  logic [1:0] wait_cnt   = '0;  // ready delay
  logic [1:0] beat       = '0;
  integer     seed       = 32'hbbb9_4168;
  word_t      mem [addr_t];      // only written words are stored

  assign o_rd_rdy    = rd_rdy_q;
  assign o_ret_valid = ret_vld_q;
  assign o_ret_last  = ret_last_q;
  assign o_ret_data  = ret_data_q;
  assign o_wr_rdy    = wr_rdy_q;
  assign o_wb_valid  = wb_vld_q;
  assign o_wb_addr   = wb_addr_q;
  assign o_wb_data   = wb_data_q;

  // untouched words hold their address xor a constant
  function automatic word_t read_word(input addr_t a);
    if (mem.exists(a)) return mem[a];
    return a ^ INIT_XOR;
  endfunction

  // ------------------------------------------------------------
  // one transfer at a time, read or write
  // ------------------------------------------------------------
  always @(posedge i_clk) begin
    rd_rdy_q   <= 1'b0;
    wr_rdy_q   <= 1'b0;
    ret_vld_q  <= 1'b0;
    ret_last_q <= 1'b0;
    wb_vld_q   <= 1'b0;
    if (i_rst) begin
      mstate <= M_IDLE;
    end else begin
      case (mstate)
        M_IDLE: begin
          if (i_wr_req && !wr_rdy_q) begin  // request still high on its ready edge
            wait_cnt <= 2'($random(seed));
            mstate   <= M_WR_WAIT;
          end else if (i_rd_req) begin
            wait_cnt <= 2'($random(seed));
            rd_base  <= i_rd_addr;
            mstate   <= M_RD_WAIT;
          end
        end
        M_RD_WAIT: begin
          if (wait_cnt == 2'd0) begin
            rd_rdy_q <= 1'b1;
            beat     <= 2'd0;
            mstate   <= M_RET;
          end else begin
            wait_cnt <= wait_cnt - 2'd1;
          end
        end
        M_RET: begin
          ret_vld_q  <= 1'b1;
          ret_data_q <= read_word(rd_base + 32'(beat) * 4);  // lowest word first
          ret_last_q <= (beat == 2'd3);
          beat       <= beat + 2'd1;
          if (beat == 2'd3) mstate <= M_IDLE;
        end
        M_WR_WAIT: begin
          if (wait_cnt == 2'd0) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
              mem[i_wr_addr + 32'(w) * 4] = i_wr_data[w*32 +: 32];
            end
            $display("mem_model: write-back of line %h", i_wr_addr);
            wr_rdy_q  <= 1'b1;
            wb_vld_q  <= 1'b1;
            wb_addr_q <= i_wr_addr;
            wb_data_q <= i_wr_data;
            mstate    <= M_IDLE;
          end else begin
            wait_cnt <= wait_cnt - 2'd1;
          end
        end
        default: mstate <= M_IDLE;
      endcase
    end
  end

endmodule

//--- verification/cache_tb.sv
// cache testbench with stimulus table, golden byte memory, bus model and final report
module cache_tb;

  import cache_pkg::*;

  localparam int    NUM_ENTRIES = 24;
  localparam int    RST_CYCLES  = 16;
  localparam int    CYC_PER_ACC = 40;  // worst case miss with write-back, with margin
  localparam int    MAX_CYCLES  = NUM_ENTRIES * CYC_PER_ACC + RST_CYCLES;
  localparam word_t MEM_XOR     = 32'h5a5a_c3c3;

  localparam logic [1:0] EXP_MISS = 2'd0;
  localparam logic [1:0] EXP_HIT  = 2'd1;
  localparam logic [1:0] EXP_ANY  = 2'd2;  // victim choice is random
  localparam logic [1:0] WB_NONE  = 2'd0;
  localparam logic [1:0] WB_YES   = 2'd1;
  localparam logic [1:0] WB_ANY   = 2'd2;

  typedef struct packed {
    logic       op;       // 1: store
    addr_t      addr;
    strb_t      strb;
    word_t      wdata;
    logic [1:0] exp_hit;
    logic [1:0] exp_wb;
  } stim_t;

  logic    clk = 1'b0;
  logic    rst;
  logic    valid;
  logic    op;
  index_t  index;
  tag_t    tag;
  offset_t offset;
  strb_t   wstrb;
  word_t   wdata;
  logic    addr_ok;
  logic    data_ok;
  word_t   rdata;
  logic    rd_req;
  addr_t   rd_addr;
  logic    rd_rdy;
  logic    ret_valid;
  logic    ret_last;
  word_t   ret_data;
  logic    wr_req;
  addr_t   wr_addr;
  line_t   wr_data;
  logic    wr_rdy;
  logic    wb_valid;
  addr_t   wb_addr;
  line_t   wb_data;

  stim_t      stim [NUM_ENTRIES];
  logic [7:0] gold_mem [addr_t];  // bytes written by stores
  addr_t      evicted_q [$];
  int         n_evicted;
  int         cycles       = 0;
  int         checks       = 0;
  int         data_errors  = 0;
  int         proto_errors = 0;

  always #2 clk = ~clk;

  cache cache_i (
    .i_clk     (clk),       .i_rst       (rst),
    .i_valid   (valid),     .i_op        (op),
    .i_index   (index),     .i_tag       (tag),
    .i_offset  (offset),    .i_wstrb     (wstrb),
    .i_wdata   (wdata),     .o_addr_ok   (addr_ok),
    .o_data_ok (data_ok),   .o_rdata     (rdata),
    .o_rd_req  (rd_req),    .o_rd_addr   (rd_addr),
    .i_rd_rdy  (rd_rdy),    .i_ret_valid (ret_valid),
    .i_ret_last(ret_last),  .i_ret_data  (ret_data),
    .o_wr_req  (wr_req),    .o_wr_addr   (wr_addr),
    .o_wr_data (wr_data),   .i_wr_rdy    (wr_rdy)
  );

  mem_model #(.INIT_XOR(MEM_XOR)) mem_i (
    .i_clk      (clk),       .i_rst       (rst),
    .i_rd_req   (rd_req),    .i_rd_addr   (rd_addr),
    .o_rd_rdy   (rd_rdy),    .o_ret_valid (ret_valid),
    .o_ret_last (ret_last),  .o_ret_data  (ret_data),
    .i_wr_req   (wr_req),    .i_wr_addr   (wr_addr),
    .i_wr_data  (wr_data),   .o_wr_rdy    (wr_rdy),
    .o_wb_valid (wb_valid),  .o_wb_addr   (wb_addr),
    .o_wb_data  (wb_data)
  );

  // ------------------------------------------------------------
  // golden memory
  // ------------------------------------------------------------
  function automatic word_t init_word(input addr_t a);
    return {a[31:2], 2'b00} ^ MEM_XOR;
  endfunction

  function automatic word_t golden_word(input addr_t a);
    addr_t base;
    word_t w;
    base = {a[31:2], 2'b00};
    w    = init_word(base);
    for (int b = 0; b < 4; b++) begin
      if (gold_mem.exists(base + 32'(b))) w[b*8 +: 8] = gold_mem[base + 32'(b)];
    end
    return w;
  endfunction

  task automatic golden_store(input addr_t a, input strb_t s, input word_t d);
    addr_t base;
    base = {a[31:2], 2'b00};
    for (int b = 0; b < 4; b++) begin
      if (s[b]) gold_mem[base + 32'(b)] = d[b*8 +: 8];
    end
  endtask

  task automatic compare_word(input word_t got, input word_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      data_errors++;
      $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic expect_flag(input logic ok, input string what);
    checks++;
    assert (ok === 1'b1) else begin
      proto_errors++;
      $display("Error at time %0t: %s", $time, what);
    end
  endtask

  function automatic stim_t make_entry(input logic st, input addr_t a, input strb_t s,
                                       input word_t d, input logic [1:0] h,
                                       input logic [1:0] wb);
    stim_t e;
    e.op      = st;
    e.addr    = a;
    e.strb    = s;
    e.wdata   = d;
    e.exp_hit = h;
    e.exp_wb  = wb;
    return e;
  endfunction

  // ------------------------------------------------------------
  // stimulus table, set 5 gets five dirty tags, set 9 five clean ones
  // ------------------------------------------------------------
  task automatic load_table();
    stim[0]  = make_entry(1'b0, 32'h0000_1050, 4'h0, 32'h0,         EXP_MISS, WB_NONE);
    stim[1]  = make_entry(1'b0, 32'h0000_1058, 4'h0, 32'h0,         EXP_HIT,  WB_NONE);
    stim[2]  = make_entry(1'b1, 32'h0000_1054, 4'h5, 32'hdead_beef, EXP_HIT,  WB_NONE);
    stim[3]  = make_entry(1'b0, 32'h0000_1054, 4'h0, 32'h0,         EXP_HIT,  WB_NONE);
    stim[4]  = make_entry(1'b1, 32'h0000_2058, 4'hc, 32'h1234_5678, EXP_MISS, WB_NONE);
    stim[5]  = make_entry(1'b0, 32'h0000_2058, 4'h0, 32'h0,         EXP_HIT,  WB_NONE);
    stim[6]  = make_entry(1'b0, 32'h0000_205c, 4'h0, 32'h0,         EXP_HIT,  WB_NONE);
    stim[7]  = make_entry(1'b1, 32'h0000_3050, 4'hf, 32'hcafe_f00d, EXP_MISS, WB_NONE);
    stim[8]  = make_entry(1'b1, 32'h0000_405c, 4'h2, 32'h00a5_5a00, EXP_MISS, WB_NONE);
    stim[9]  = make_entry(1'b1, 32'h0000_5050, 4'h9, 32'h7788_99aa, EXP_MISS, WB_YES);
    stim[10] = make_entry(1'b0, 32'h0000_5050, 4'h0, 32'h0,         EXP_HIT,  WB_NONE);
    stim[11] = make_entry(1'b0, 32'h0000_1054, 4'h0, 32'h0,         EXP_ANY,  WB_ANY);
    stim[12] = make_entry(1'b0, 32'h0000_2058, 4'h0, 32'h0,         EXP_ANY,  WB_ANY);
    stim[13] = make_entry(1'b0, 32'h0000_3050, 4'h0, 32'h0,         EXP_ANY,  WB_ANY);
    stim[14] = make_entry(1'b0, 32'h0000_405c, 4'h0, 32'h0,         EXP_ANY,  WB_ANY);
    stim[15] = make_entry(1'b0, 32'h0000_0090, 4'h0, 32'h0,         EXP_MISS, WB_NONE);
    stim[16] = make_entry(1'b0, 32'h0000_0494, 4'h0, 32'h0,         EXP_MISS, WB_NONE);
    stim[17] = make_entry(1'b0, 32'h0000_0898, 4'h0, 32'h0,         EXP_MISS, WB_NONE);
    stim[18] = make_entry(1'b0, 32'h0000_0c9c, 4'h0, 32'h0,         EXP_MISS, WB_NONE);
    stim[19] = make_entry(1'b0, 32'h0000_1090, 4'h0, 32'h0,         EXP_MISS, WB_NONE);
    stim[20] = make_entry(1'b0, 32'h0000_1094, 4'h0, 32'h0,         EXP_HIT,  WB_NONE);
    stim[21] = make_entry(1'b1, 32'h0000_00a8, 4'h6, 32'h0bad_c0de, EXP_MISS, WB_NONE);
    stim[22] = make_entry(1'b0, 32'h0000_00a8, 4'h0, 32'h0,         EXP_HIT,  WB_NONE);
    stim[23] = make_entry(1'b0, 32'h0000_0c94, 4'h0, 32'h0,         EXP_ANY,  WB_NONE);
  endtask

  // one cpu request from issue to data_ok
  task automatic run_access(input stim_t s);
    int   lat;
    logic rd_seen;
    logic wr_seen;
    logic done;
    lat     = 0;
    rd_seen = 1'b0;
    wr_seen = 1'b0;
    done    = 1'b0;
    @(negedge clk);
    valid  = 1'b1;
    op     = s.op;
    tag    = s.addr[31:10];
    index  = s.addr[9:4];
    offset = s.addr[3:0];
    wstrb  = s.strb;
    wdata  = s.wdata;
    #1;
    while (!addr_ok) begin
      @(negedge clk);
      #1;
    end
    while (!done) begin
      @(negedge clk);
      valid = 1'b0;                         // taken at the last edge
      lat++;
      if (rd_req && !rd_seen) begin
        rd_seen = 1'b1;
        compare_word(rd_addr, {s.addr[31:4], 4'h0},
                     $sformatf("line read address for %h", s.addr));
      end
      if (wr_req) wr_seen = 1'b1;
      done = data_ok;
    end
    if (s.exp_hit == EXP_HIT)
      expect_flag(!rd_seen && !wr_seen, $sformatf("bus request on expected hit to %h", s.addr));
    if (s.exp_hit == EXP_MISS)
      expect_flag(rd_seen, $sformatf("no line read on expected miss to %h", s.addr));
    if (!rd_seen)
      expect_flag(lat == 2, $sformatf("hit to %h took %0d cycles instead of 2", s.addr, lat));
    if (s.exp_wb == WB_YES)
      expect_flag(wr_seen, $sformatf("no write-back when %h evicts a dirty line", s.addr));
    if (s.exp_wb == WB_NONE)
      expect_flag(!wr_seen, $sformatf("unexpected write-back during access to %h", s.addr));
    if (s.op) golden_store(s.addr, s.strb, s.wdata);
    else compare_word(rdata, golden_word(s.addr), $sformatf("read data at %h", s.addr));
  endtask

  // ------------------------------------------------------------
  // write-back data against golden memory
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (wb_valid) begin
      evicted_q.push_back(wb_addr);
      expect_flag(wb_addr[3:0] == 4'h0,
                  $sformatf("write-back address %h not line aligned", wb_addr));
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        compare_word(wb_data[w*32 +: 32], golden_word(wb_addr + 32'(w) * 4),
                     $sformatf("write-back word %0d of line %h", w, wb_addr));
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      proto_errors++;
      $display("Error: timeout, run still busy after %0d cycles", MAX_CYCLES);
      $display("report: %0d checks, %0d data errors, %0d protocol errors",
               checks, data_errors, proto_errors);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    rst    = 1'b1;
    valid  = 1'b0;
    op     = 1'b0;
    index  = '0;
    tag    = '0;
    offset = '0;
    wstrb  = '0;
    wdata  = '0;
    load_table();
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    expect_flag(!data_ok && !rd_req && !wr_req && !addr_ok, "cache outputs not idle after reset");

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_access(stim[i]);
    end

    // every evicted line must read back its golden words
    n_evicted = evicted_q.size();
    expect_flag(n_evicted > 0, "no write-back seen although dirty lines were evicted");
    for (int i = 0; i < n_evicted; i++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        run_access(make_entry(1'b0, evicted_q[i] + 32'(w) * 4, 4'h0, 32'h0, EXP_ANY, WB_ANY));
      end
    end

    $display("report: %0d checks, %0d data errors, %0d protocol errors",
             checks, data_errors, proto_errors);
    if (data_errors + proto_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
source/cache_pkg.sv
source/data_sram.sv
source/tag_array.sv
source/cache_ctrl.sv
source/cache.sv
verification/mem_model.sv
verification/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - source/cache_pkg.sv
  - source/data_sram.sv
  - source/tag_array.sv
  - source/cache_ctrl.sv
  - source/cache.sv
  - target: test
    files:
      - verification/mem_model.sv
      - verification/cache_tb.sv
